// ==== build.f ====
design/rvDecodePkg.sv
design/writebackIf.sv
design/regReadIf.sv
design/registerFile.sv
design/immGen.sv
design/loadWriteback.sv
design/decodeStage.sv
verification/decodeStageTb.sv

// ==== Makefile ====
# Verilator flow for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStageTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASSTEXT  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# Result comes from the log, not the exit code of the pipe
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSTEXT)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verification/decodeStageTb.sv ====
module decodeStageTb;
    import rvDecodePkg::*;

    // Watchdog sizing
    localparam int numTests    = 6;
    localparam int vecPerTest  = 200;
    localparam int resetCycles = 10;
    localparam int clkPeriod   = 10;
    localparam int limitTime   = 2 * (numTests * vecPerTest + resetCycles) * clkPeriod;

    logic        clk;
    logic        arstN;
    logic [31:0] inst;
    logic [4:0]  wbRdAddr;
    logic [31:0] aluResult;
    logic [31:0] memData;
    logic [31:0] pc4;
    logic        regWrite;
    logic        memToReg;
    logic        wbLink;
    logic [2:0]  wbFunct3;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] imm32;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1Addr;
    logic [4:0]  rs2Addr;
    logic [4:0]  rdAddr;
    logic [31:0] ecallCode;
    logic [31:0] ecallArg;

    // Shadow register file and expected outputs
    logic [31:0] shadow [0:31];
    logic [31:0] expRd1;
    logic [31:0] expRd2;
    logic [31:0] expImm;
    logic [31:0] expCode;
    logic [31:0] expArg;
    logic        checkOn;

    integer seed;
    int     errCount;
    int     errAtStart;
    int     testsRun;
    int     testsOk;

    logic [6:0] opList [10] = '{opLui, opAuipc, opJal, opJalr, opBranch,
                                opLoad, opStore, opImm, opReg, opSystem};
    // Five legal load widths, then one undefined code
    logic [2:0] f3List [6] = '{f3Lb, f3Lh, f3Lw, f3Lbu, f3Lhu, 3'b011};

    decodeStage dut0 (
        .clk       (clk),
        .arstN     (arstN),
        .inst      (inst),
        .wbRdAddr  (wbRdAddr),
        .aluResult (aluResult),
        .memData   (memData),
        .pc4       (pc4),
        .regWrite  (regWrite),
        .memToReg  (memToReg),
        .wbLink    (wbLink),
        .wbFunct3  (wbFunct3),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .imm32     (imm32),
        .funct3    (funct3),
        .funct7    (funct7),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rdAddr    (rdAddr),
        .ecallCode (ecallCode),
        .ecallArg  (ecallArg)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // -------------------------------------------------------------------------
    // Reference model
    // -------------------------------------------------------------------------

    // Immediate straight from the RV32I bit layout
    function automatic logic [31:0] refImm(input logic [31:0] w);
        case (w[6:0])
            opLoad, opImm, opJalr: return {{20{w[31]}}, w[31:20]};
            opStore:               return {{20{w[31]}}, w[31:25], w[11:7]};
            opBranch:              return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            opLui, opAuipc:        return {w[31:12], 12'h000};
            opJal:                 return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:               return 32'h0;
        endcase
    endfunction

    // Link beats load, load beats ALU
    function automatic logic [31:0] refWdata(input logic lnk, input logic m2r,
                                             input logic [2:0] f3, input logic [31:0] mem,
                                             input logic [31:0] alu, input logic [31:0] pcv);
        if (lnk) begin
            return pcv;
        end
        if (!m2r) begin
            return alu;
        end
        case (f3)
            3'b000:  return {{24{mem[7]}}, mem[7:0]};
            3'b001:  return {{16{mem[15]}}, mem[15:0]};
            3'b010:  return mem;
            3'b100:  return {24'h0, mem[7:0]};
            3'b101:  return {16'h0, mem[15:0]};
            default: return 32'h0;
        endcase
    endfunction

    // -------------------------------------------------------------------------
    // Stimulus and comparison
    // -------------------------------------------------------------------------

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        errCount++;
    endtask

    // One vector per cycle, applied on the falling edge
    task automatic driveVector(input logic [31:0] instIn, input logic [4:0] rd,
                               input logic [31:0] alu, input logic [31:0] mem,
                               input logic [31:0] pcv, input logic we, input logic m2r,
                               input logic lnk, input logic [2:0] f3);
        @(negedge clk);
        inst      = instIn;
        wbRdAddr  = rd;
        aluResult = alu;
        memData   = mem;
        pc4       = pcv;
        regWrite  = we;
        memToReg  = m2r;
        wbLink    = lnk;
        wbFunct3  = f3;
        // Shadow holds the state after the coming rising edge
        if (arstN && we && (rd != 5'd0)) begin
            shadow[rd] = refWdata(lnk, m2r, f3, mem, alu, pcv);
        end
        expRd1  = shadow[instIn[19:15]];
        expRd2  = shadow[instIn[24:20]];
        expImm  = refImm(instIn);
        expArg  = shadow[regA0];
        expCode = shadow[regA7];
        checkOn = 1'b1;
    endtask

    // Compare once the edge has settled
    always @(posedge clk) begin
        #1;
        if (checkOn) begin
            if (rdata1 !== expRd1) reportMismatch("rdata1", rdata1, expRd1);
            if (rdata2 !== expRd2) reportMismatch("rdata2", rdata2, expRd2);
            if (imm32 !== expImm) reportMismatch("imm32", imm32, expImm);
            if (funct3 !== inst[14:12]) reportMismatch("funct3", 32'(funct3), 32'(inst[14:12]));
            if (funct7 !== inst[31:25]) reportMismatch("funct7", 32'(funct7), 32'(inst[31:25]));
            if (rs1Addr !== inst[19:15]) reportMismatch("rs1Addr", 32'(rs1Addr), 32'(inst[19:15]));
            if (rs2Addr !== inst[24:20]) reportMismatch("rs2Addr", 32'(rs2Addr), 32'(inst[24:20]));
            if (rdAddr !== inst[11:7]) reportMismatch("rdAddr", 32'(rdAddr), 32'(inst[11:7]));
            if (ecallArg !== expArg) reportMismatch("ecallArg", ecallArg, expArg);
            if (ecallCode !== expCode) reportMismatch("ecallCode", ecallCode, expCode);
        end
    end

    // Idle vector, then one line per test
    task automatic closeTest(input string name);
        driveVector(32'h0, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 3'b000);
        testsRun++;
        if (errCount == errAtStart) begin
            testsOk++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errCount - errAtStart);
        end
        errAtStart = errCount;
    endtask

    // -------------------------------------------------------------------------
    // Tests
    // -------------------------------------------------------------------------

    // Writes attempted during reset must not land
    task automatic resetCheck();
        for (int i = 0; i < resetCycles; i++) begin
            driveVector($random(seed), $random(seed), $random(seed), $random(seed),
                        $random(seed), i < resetCycles - 1, 1'b0, 1'b0, 3'b010);
        end
        arstN = 1'b1;
        for (int i = 0; i < 5; i++) begin
            driveVector($random(seed), 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 3'b000);
        end
        closeTest("reset");
    endtask

    task automatic aluWrites();
        instWord_u  w;
        logic [4:0] rd;
        for (int i = 0; i < 200; i++) begin
            w = $random(seed);
            w.r.opcode = opReg;
            rd = $random(seed);
            // Regular x0 writes with nonzero data
            if (i % 20 == 0) rd = 5'd0;
            if (i % 4 == 0) w.r.rs1 = rd;
            driveVector(w, rd, $random(seed), $random(seed), $random(seed),
                        1'b1, 1'b0, 1'b0, 3'b000);
        end
        closeTest("alu");
    endtask

    task automatic loadExtension();
        instWord_u  w;
        logic [4:0] rd;
        for (int f = 0; f < 6; f++) begin
            for (int i = 0; i < 30; i++) begin
                rd = $random(seed);
                if (rd == 5'd0) rd = 5'd1;
                w = $random(seed);
                w.i.opcode = opLoad;
                w.r.rs1 = rd;
                driveVector(w, rd, $random(seed), $random(seed), $random(seed),
                            1'b1, 1'b1, 1'b0, f3List[f]);
            end
        end
        closeTest("load");
    endtask

    // memToReg stays low, a real jump never loads
    task automatic linkPriority();
        instWord_u  w;
        logic [4:0] rd;
        for (int i = 0; i < 50; i++) begin
            rd = $random(seed);
            w = $random(seed);
            w.r.opcode = opJal;
            w.r.rs2 = rd;
            driveVector(w, rd, $random(seed), $random(seed), $random(seed),
                        1'b1, 1'b0, 1'b1, $random(seed));
        end
        closeTest("link");
    endtask

    task automatic immFields();
        instWord_u w;
        for (int op = 0; op < 10; op++) begin
            for (int i = 0; i < 20; i++) begin
                w = $random(seed);
                w.u.opcode = opList[op];
                driveVector(w, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 3'b000);
            end
        end
        closeTest("immediate");
    endtask

    // a0 and a7 alternately
    task automatic ecallTaps();
        instWord_u w;
        for (int i = 0; i < 20; i++) begin
            w = $random(seed);
            w.i.opcode = opSystem;
            driveVector(w, (i % 2 == 0) ? 5'(regA0) : 5'(regA7), $random(seed),
                        $random(seed), $random(seed), 1'b1, 1'b0, 1'b0, 3'b000);
        end
        closeTest("ecall");
    endtask

    // -------------------------------------------------------------------------
    // Sequence and watchdog
    // -------------------------------------------------------------------------

    initial begin
        seed       = 32'h1819_2d06;
        arstN      = 1'b0;
        inst       = 32'h0;
        wbRdAddr   = 5'd0;
        aluResult  = 32'h0;
        memData    = 32'h0;
        pc4        = 32'h0;
        regWrite   = 1'b0;
        memToReg   = 1'b0;
        wbLink     = 1'b0;
        wbFunct3   = 3'b000;
        checkOn    = 1'b0;
        errCount   = 0;
        errAtStart = 0;
        testsRun   = 0;
        testsOk    = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'h0;
        end
        resetCheck();
        aluWrites();
        loadExtension();
        linkPriority();
        immFields();
        ecallTaps();
        $display("tests run %0d, ok %0d, with errors %0d, total errors %0d",
                 testsRun, testsOk, testsRun - testsOk, errCount);
        if (errCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(limitTime);
        $display("Watchdog expired after %0t, the tests did not finish", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== design/decodeStage.sv ====
module decodeStage (
    input  logic                             clk,
    input  logic                             arstN,
    // Fetched instruction
    input  logic [rvDecodePkg::xLen-1:0]     inst,
    // Writeback bundle
    input  logic [rvDecodePkg::regAddrW-1:0] wbRdAddr,
    input  logic [rvDecodePkg::xLen-1:0]     aluResult,
    input  logic [rvDecodePkg::xLen-1:0]     memData,
    input  logic [rvDecodePkg::xLen-1:0]     pc4,
    input  logic                             regWrite,
    input  logic                             memToReg,
    input  logic                             wbLink,
    input  logic [2:0]                       wbFunct3,
    // Operands and decoded fields
    output logic [rvDecodePkg::xLen-1:0]     rdata1,
    output logic [rvDecodePkg::xLen-1:0]     rdata2,
    output logic [rvDecodePkg::xLen-1:0]     imm32,
    output logic [2:0]                       funct3,
    output logic [6:0]                       funct7,
    output logic [rvDecodePkg::regAddrW-1:0] rs1Addr,
    output logic [rvDecodePkg::regAddrW-1:0] rs2Addr,
    output logic [rvDecodePkg::regAddrW-1:0] rdAddr,
    // Ecall taps, a7 and a0
    output logic [rvDecodePkg::xLen-1:0]     ecallCode,
    output logic [rvDecodePkg::xLen-1:0]     ecallArg
);
    import rvDecodePkg::*;

    // ------------------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------------------

    instWord_u instView;

    // Register fields share positions across formats
    assign instView = inst;
    assign rs1Addr  = instView.r.rs1;
    assign rs2Addr  = instView.r.rs2;
    assign rdAddr   = instView.r.rd;
    assign funct3   = instView.r.funct3;
    assign funct7   = instView.r.funct7;

    // ------------------------------------------------------------------------
    // Buses
    // ------------------------------------------------------------------------

    writebackIf wbBus (.clk(clk));
    regReadIf   readBus ();

    // Writeback ports onto the bundle
    assign wbBus.rdAddr    = wbRdAddr;
    assign wbBus.aluResult = aluResult;
    assign wbBus.memData   = memData;
    assign wbBus.pc4       = pc4;
    assign wbBus.regWrite  = regWrite;
    assign wbBus.memToReg  = memToReg;
    assign wbBus.link      = wbLink;
    assign wbBus.funct3    = wbFunct3;

    // Source addresses out, operands back
    assign readBus.raddr1 = rs1Addr;
    assign readBus.raddr2 = rs2Addr;
    assign rdata1         = readBus.rdata1;
    assign rdata2         = readBus.rdata2;

    // Write port between selector and regfile
    logic [regAddrW-1:0] waddr;
    logic [xLen-1:0]     wdata;
    logic                we;

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------

    loadWriteback uLoadWriteback (
        .wb    (wbBus.sink),
        .waddr (waddr),
        .wdata (wdata),
        .we    (we)
    );

    registerFile uRegisterFile (
        .clk      (clk),
        .arstN    (arstN),
        .readPort (readBus.responder),
        .waddr    (waddr),
        .wdata    (wdata),
        .we       (we),
        .a0Data   (ecallArg),
        .a7Data   (ecallCode)
    );

    immGen uImmGen (
        .inst  (instView),
        .imm32 (imm32)
    );

endmodule

// ==== design/loadWriteback.sv ====
module loadWriteback (
    writebackIf.sink                         wb,
    output logic [rvDecodePkg::regAddrW-1:0] waddr,
    output logic [rvDecodePkg::xLen-1:0]     wdata,
    output logic                             we
);
    import rvDecodePkg::*;

    // ------------------------------------------------------------------------
    // Load extension
    // ------------------------------------------------------------------------

    logic [xLen-1:0] loadValue;

    // Low byte or half of the raw word
    always_comb begin
        case (wb.funct3)
            // Signed byte
            f3Lb:    loadValue = {{24{wb.memData[7]}}, wb.memData[7:0]};
            // Signed half, sign from bit 15
            f3Lh:    loadValue = {{16{wb.memData[15]}}, wb.memData[15:0]};
            // Full word
            f3Lw:    loadValue = wb.memData;
            // Unsigned byte
            f3Lbu:   loadValue = {24'b0, wb.memData[7:0]};
            // Unsigned half
            f3Lhu:   loadValue = {16'b0, wb.memData[15:0]};
            // Undefined load width
            default: loadValue = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Write data select
    // ------------------------------------------------------------------------

    // Link first, then load, then ALU
    always_comb begin
        if (wb.link) begin
            wdata = wb.pc4;
        end else if (wb.memToReg) begin
            wdata = loadValue;
        end else begin
            wdata = wb.aluResult;
        end
    end

    // Write port follows the bundle
    assign waddr = wb.rdAddr;
    assign we    = wb.regWrite;

    // Jumps never come from memory
    linkNotLoad: assert property (
        @(posedge wb.clk) wb.regWrite |-> !(wb.link && wb.memToReg)
    ) else $error("writeback flags both link and memToReg");

endmodule

// ==== design/immGen.sv ====
module immGen (
    input  rvDecodePkg::instWord_u       inst,
    output logic [rvDecodePkg::xLen-1:0] imm32
);
    import rvDecodePkg::*;

    // ------------------------------------------------------------------------
    // Per-format immediates
    // ------------------------------------------------------------------------

    logic [xLen-1:0] immI;
    logic [xLen-1:0] immS;
    logic [xLen-1:0] immB;
    logic [xLen-1:0] immU;
    logic [xLen-1:0] immJ;

    // Sign bit is inst[31] in every format
    assign immI = {{20{inst.i.imm11_0[11]}}, inst.i.imm11_0};

    // Store offset rejoined
    assign immS = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};

    // Branch offset, even only
    assign immB = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                   inst.b.imm10_5, inst.b.imm4_1, 1'b0};

    // Upper 20 bits, low 12 zero
    assign immU = {inst.u.imm31_12, 12'b0};

    // Jump offset, even only
    assign immJ = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                   inst.j.imm11, inst.j.imm10_1, 1'b0};

    // ------------------------------------------------------------------------
    // Format select by opcode
    // ------------------------------------------------------------------------

    always_comb begin
        case (inst.r.opcode)
            // I format
            opLoad, opImm, opJalr: imm32 = immI;
            // S format
            opStore:               imm32 = immS;
            // B format
            opBranch:              imm32 = immB;
            // U format
            opLui, opAuipc:        imm32 = immU;
            // J format
            opJal:                 imm32 = immJ;
            // R, system and unknown carry no immediate
            default:               imm32 = '0;
        endcase
    end

endmodule

// ==== design/registerFile.sv ====
module registerFile (
    input  logic                             clk,
    input  logic                             arstN,
    regReadIf.responder                      readPort,
    input  logic [rvDecodePkg::regAddrW-1:0] waddr,
    input  logic [rvDecodePkg::xLen-1:0]     wdata,
    input  logic                             we,
    output logic [rvDecodePkg::xLen-1:0]     a0Data,
    output logic [rvDecodePkg::xLen-1:0]     a7Data
);
    import rvDecodePkg::*;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // x1..x31 only, x0 has no flops
    logic [xLen-1:0] regs [1:numRegs-1];

    // Write on rising edge
    // Writes to x0 dropped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------------

    // Combinational, no bypass
    // Same-cycle write shows old value
    assign readPort.rdata1 = (readPort.raddr1 == '0) ? '0 : regs[readPort.raddr1];
    assign readPort.rdata2 = (readPort.raddr2 == '0) ? '0 : regs[readPort.raddr2];

    // Ecall taps, argument and service number
    assign a0Data = regs[regA0];
    assign a7Data = regs[regA7];

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // x0 reads zero on both ports, every cycle
    x0ReadsZero: assert property (
        @(posedge clk)
        ((readPort.raddr1 != '0) || (readPort.rdata1 == '0)) &&
        ((readPort.raddr2 != '0) || (readPort.rdata2 == '0))
    ) else $error("x0 read returned nonzero data");

    // Untargeted registers hold their value across an edge
    for (genvar g = 1; g < numRegs; g++) begin : gHold
        holdUntargeted: assert property (
            @(posedge clk) disable iff (!arstN)
            (!we || (waddr != regAddrW'(g))) |=> $stable(regs[g])
        ) else $error("register x%0d changed without a write", g);
    end

endmodule

// ==== design/regReadIf.sv ====
interface regReadIf;
    import rvDecodePkg::*;

    // Source register addresses
    logic [regAddrW-1:0] raddr1;
    logic [regAddrW-1:0] raddr2;
    // Read data, same cycle
    logic [xLen-1:0]     rdata1;
    logic [xLen-1:0]     rdata2;

    // Decode side asks
    modport requester (
        output raddr1, raddr2,
        input  rdata1, rdata2
    );

    // Register file answers
    modport responder (
        input  raddr1, raddr2,
        output rdata1, rdata2
    );

endinterface

// ==== design/writebackIf.sv ====
interface writebackIf (
    input logic clk
);
    import rvDecodePkg::*;

    // Destination and candidate write values
    logic [regAddrW-1:0] rdAddr;
    logic [xLen-1:0]     aluResult;
    logic [xLen-1:0]     memData;
    logic [xLen-1:0]     pc4;

    // Control from the last stage
    logic                regWrite;
    logic                memToReg;
    // JAL or JALR in writeback
    logic                link;
    // Load funct3 carried with the instruction
    logic [2:0]          funct3;

    // Producer side, the pipeline top
    modport source (
        output rdAddr, aluResult, memData, pc4, regWrite, memToReg, link, funct3
    );

    // Consumer side, clock kept for checks
    modport sink (
        input clk, rdAddr, aluResult, memData, pc4, regWrite, memToReg, link, funct3
    );

endinterface

// ==== design/rvDecodePkg.sv ====
package rvDecodePkg;

    // ----------------------------------------------------------------------------
    // Widths and counts
    // ----------------------------------------------------------------------------

    // Data word width
    localparam int xLen     = 32;
    // Register address width
    localparam int regAddrW = 5;
    // Architectural register count, x0 included
    localparam int numRegs  = 32;

    // ABI registers watched by the ecall logic
    localparam int regA0 = 10;
    localparam int regA7 = 17;

    // ----------------------------------------------------------------------------
    // Major opcodes, RV32I base set
    // ----------------------------------------------------------------------------

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opSystem = 7'b1110011;

    // Load width and signedness in funct3
    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;

    // ----------------------------------------------------------------------------
    // Instruction formats
    // ----------------------------------------------------------------------------

    // Register-register
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmt_t;

    // Immediate, loads and JALR
    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmt_t;

    // Store, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sFmt_t;

    // Branch, bit 11 sits where S keeps bit 0
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmt_t;

    // Upper immediate
    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFmt_t;

    // Jump, scrambled 20-bit offset
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFmt_t;

    // One 32-bit word, six views
    typedef union packed {
        rFmt_t r;
        iFmt_t i;
        sFmt_t s;
        bFmt_t b;
        uFmt_t u;
        jFmt_t j;
    } instWord_u;

endpackage
